// File: sa_geometry_pkg.sv
`default_nettype none

package sa_geometry_pkg;

    // grid size, also the A and B vector lengths
    localparam int ROWS = 4;
    localparam int COLS = 4;

    localparam int DATA_W = 8;

    // deepest inner dimension, sets the operand bank depth
    localparam int K_MAX = 16;
    localparam int K_W   = $clog2(K_MAX + 1);

    // full product plus headroom for K_MAX additions
    localparam int ACC_W = 2 * DATA_W + $clog2(K_MAX);

    typedef logic [DATA_W-1:0] element_t;
    typedef logic [ACC_W-1:0]  acc_t;

endpackage

`default_nettype wire

// File: sa_stream_pkg.sv
`default_nettype none

package sa_stream_pkg;

    import sa_geometry_pkg::*;

    localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

    // one column of A, one row of B
    typedef element_t [ROWS-1:0] a_vec_t;
    typedef element_t [COLS-1:0] b_vec_t;

    typedef struct packed {
        logic           strobe;
        logic [K_W-1:0] step;
        a_vec_t         vec;
    } a_load_t;

    typedef struct packed {
        logic           strobe;
        logic [K_W-1:0] step;
        b_vec_t         vec;
    } b_load_t;

    typedef acc_t [COLS-1:0] sum_row_t;

    typedef struct packed {
        logic             valid;
        logic [ROW_W-1:0] row;
        sum_row_t         sums;
    } result_beat_t;

endpackage

`default_nettype wire

// File: operand_bank.sv
`default_nettype none

module operand_bank #(
    parameter int  DEPTH = 16,
    parameter type vec_t = logic [31:0]
) (
    input  wire logic                                        clk,
    input  wire logic                                        reset_n,
    input  wire logic [$bits(vec_t)+sa_geometry_pkg::K_W:0]  load_i,
    input  wire logic                                        rd_en_i,
    input  wire logic [sa_geometry_pkg::K_W-1:0]             rd_step_i,
    output vec_t                                             vec_o
);

    import sa_geometry_pkg::*;

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // field order as in a_load_t and b_load_t
    typedef struct packed {
        logic           strobe;
        logic [K_W-1:0] step;
        vec_t           vec;
    } load_t;

    load_t load;
    vec_t  mem [DEPTH];

    assign load = load_i;

    always_ff @(posedge clk) begin
        if (load.strobe) begin
            mem[load.step[ADDR_W-1:0]] <= load.vec;
        end
    end

    // zero outside a read so idle lanes add nothing
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vec_o <= '0;
        end else if (rd_en_i) begin
            vec_o <= mem[rd_step_i[ADDR_W-1:0]];
        end else begin
            vec_o <= '0;
        end
    end

    load_step_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        load.strobe |-> (load.step < K_W'(DEPTH))
    ) else $error("load step %0d beyond bank depth %0d", load.step, DEPTH);

endmodule

`default_nettype wire

// File: skew_feeder.sv
`default_nettype none

module skew_feeder #(
    parameter int LANES = 4
) (
    input  wire logic                                  clk,
    input  wire logic                                  reset_n,
    input  wire sa_geometry_pkg::element_t [LANES-1:0] vec_i,
    output sa_geometry_pkg::element_t [LANES-1:0]      lanes_o
);

    import sa_geometry_pkg::*;

    // lane 0 enters the grid edge without delay
    assign lanes_o[0] = vec_i[0];

    for (genvar i = 1; i < LANES; i++) begin : g_lane
        element_t [i-1:0] chain_q;

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                chain_q <= '0;
            end else begin
                chain_q[0] <= vec_i[i];
                for (int s = 1; s < i; s++) begin
                    chain_q[s] <= chain_q[s-1];
                end
            end
        end

        // i stages deep
        assign lanes_o[i] = chain_q[i-1];
    end

endmodule

`default_nettype wire

// File: mac_cell.sv
`default_nettype none

module mac_cell (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire logic                      clear_i,
    input  wire sa_geometry_pkg::element_t a_i,
    input  wire sa_geometry_pkg::element_t b_i,
    output sa_geometry_pkg::element_t      a_o,
    output sa_geometry_pkg::element_t      b_o,
    output sa_geometry_pkg::acc_t          sum_o
);

    import sa_geometry_pkg::*;

    logic [2*DATA_W-1:0] product;

    assign product = a_i * b_i;

    // operands move on to the right and lower neighbours
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            a_o <= a_i;
            b_o <= b_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_o <= '0;
        end else if (clear_i) begin
            sum_o <= '0;
        end else begin
            sum_o <= sum_o + acc_t'(product);
        end
    end

endmodule

`default_nettype wire

// File: systolic_grid.sv
`default_nettype none

module systolic_grid (
    input  wire logic                                           clk,
    input  wire logic                                           reset_n,
    input  wire logic                                           clear_i,
    input  wire sa_stream_pkg::a_vec_t                          a_edge_i,
    input  wire sa_stream_pkg::b_vec_t                          b_edge_i,
    output sa_stream_pkg::sum_row_t [sa_geometry_pkg::ROWS-1:0] sums_o
);

    import sa_geometry_pkg::*;

    // a travels right along a row, b travels down a column
    element_t a_h [ROWS][COLS+1];
    element_t b_v [ROWS+1][COLS];

    for (genvar r = 0; r < ROWS; r++) begin : g_left
        assign a_h[r][0] = a_edge_i[r];
    end

    for (genvar c = 0; c < COLS; c++) begin : g_top
        assign b_v[0][c] = b_edge_i[c];
    end

    // cell (r,c) ends up holding C[r][c]
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            mac_cell u_mac_cell (
                .clk     (clk),
                .reset_n (reset_n),
                .clear_i (clear_i),
                .a_i     (a_h[r][c]),
                .b_i     (b_v[r][c]),
                .a_o     (a_h[r][c+1]),
                .b_o     (b_v[r+1][c]),
                .sum_o   (sums_o[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// File: matmul_ctrl.sv
`default_nettype none

module matmul_ctrl #(
    parameter int COMPUTE_SLACK = 2
) (
    input  wire logic                            clk,
    input  wire logic                            reset_n,
    input  wire logic                            start_i,
    input  wire logic [sa_geometry_pkg::K_W-1:0] k_len_i,
    input  wire logic                            done_i,
    output logic                                 rd_en_o,
    output logic [sa_geometry_pkg::K_W-1:0]      rd_step_o,
    output logic                                 clear_o,
    output logic                                 snap_o
);

    import sa_geometry_pkg::*;

    // last product lands in the far corner ROWS+COLS-1 cycles after the last read
    localparam int WAIT_CYCLES = ROWS + COLS + COMPUTE_SLACK - 1;
    localparam int WAIT_W      = $clog2(WAIT_CYCLES + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FEED,
        S_WAIT
    } state_t;

    state_t            state_q;
    logic [K_W-1:0]    k_len_q;
    logic [WAIT_W-1:0] wait_q;
    logic              busy;
    logic              start_accept;

    assign busy         = (state_q != S_IDLE);
    assign start_accept = start_i && !busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= S_IDLE;
            k_len_q   <= '0;
            wait_q    <= '0;
            rd_en_o   <= 1'b0;
            rd_step_o <= '0;
            clear_o   <= 1'b0;
            snap_o    <= 1'b0;
        end else begin
            clear_o <= start_accept;
            snap_o  <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_accept) begin
                        state_q   <= S_FEED;
                        k_len_q   <= k_len_i;
                        rd_en_o   <= 1'b1;
                        rd_step_o <= '0;
                    end
                end
                S_FEED: begin
                    if (rd_step_o == k_len_q - 1'b1) begin
                        state_q <= S_WAIT;
                        rd_en_o <= 1'b0;
                        wait_q  <= WAIT_W'(WAIT_CYCLES);
                    end else begin
                        rd_step_o <= rd_step_o + 1'b1;
                    end
                end
                S_WAIT: begin
                    // snap once as the count runs out, then hold until the drain ends
                    if (wait_q != '0) begin
                        wait_q <= wait_q - 1'b1;
                        snap_o <= (wait_q == WAIT_W'(1));
                    end
                    if (done_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    no_snap_in_feed: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state_q == S_FEED) |-> !snap_o
    ) else $error("snap issued while operands are still being read");

endmodule

`default_nettype wire

// File: result_drain.sv
`default_nettype none

module result_drain (
    input  wire logic                                           clk,
    input  wire logic                                           reset_n,
    input  wire logic                                           snap_i,
    input  wire sa_stream_pkg::sum_row_t [sa_geometry_pkg::ROWS-1:0] sums_i,
    output sa_stream_pkg::result_beat_t                         result_o,
    output logic                                                done_o
);

    import sa_geometry_pkg::*;
    import sa_stream_pkg::*;

    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(ROWS - 1);

    sum_row_t [ROWS-1:0] hold_q;
    logic [ROW_W-1:0]    row_q;
    logic                active_q;

    // the copy lets the grid clear for the next run
    always_ff @(posedge clk) begin
        if (snap_i) begin
            hold_q <= sums_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active_q <= 1'b0;
            row_q    <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= active_q && (row_q == LAST_ROW);
            if (snap_i) begin
                active_q <= 1'b1;
                row_q    <= '0;
            end else if (active_q) begin
                if (row_q == LAST_ROW) begin
                    active_q <= 1'b0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end
        end
    end

    // one row per cycle, row 0 first
    assign result_o.valid = active_q;
    assign result_o.row   = row_q;
    assign result_o.sums  = hold_q[row_q];

    no_snap_while_draining: assert property (
        @(posedge clk) disable iff (!reset_n)
        snap_i |-> !active_q
    ) else $error("snap arrived during a drain, row %0d", row_q);

endmodule

`default_nettype wire

// File: matmul_top.sv
`default_nettype none

module matmul_top #(
    parameter int COMPUTE_SLACK = 2
) (
    input  wire logic                            clk,
    input  wire logic                            reset_n,
    input  wire sa_stream_pkg::a_load_t          a_load_i,
    input  wire sa_stream_pkg::b_load_t          b_load_i,
    input  wire logic [sa_geometry_pkg::K_W-1:0] k_len_i,
    input  wire logic                            start_i,
    output sa_stream_pkg::result_beat_t          result_o,
    output logic                                 done_o
);

    import sa_geometry_pkg::*;
    import sa_stream_pkg::*;

    logic                rd_en;
    logic [K_W-1:0]      rd_step;
    logic                clear;
    logic                snap;
    a_vec_t              a_rd_vec;
    a_vec_t              a_edge;
    b_vec_t              b_rd_vec;
    b_vec_t              b_edge;
    sum_row_t [ROWS-1:0] sums;

    matmul_ctrl #(
        .COMPUTE_SLACK (COMPUTE_SLACK)
    ) u_matmul_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (start_i),
        .k_len_i   (k_len_i),
        .done_i    (done_o),
        .rd_en_o   (rd_en),
        .rd_step_o (rd_step),
        .clear_o   (clear),
        .snap_o    (snap)
    );

    // A columns on the left edge
    operand_bank #(
        .DEPTH (K_MAX),
        .vec_t (a_vec_t)
    ) u_a_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_i    (a_load_i),
        .rd_en_i   (rd_en),
        .rd_step_i (rd_step),
        .vec_o     (a_rd_vec)
    );

    skew_feeder #(
        .LANES (ROWS)
    ) u_a_skew (
        .clk     (clk),
        .reset_n (reset_n),
        .vec_i   (a_rd_vec),
        .lanes_o (a_edge)
    );

    // B rows on the top edge
    operand_bank #(
        .DEPTH (K_MAX),
        .vec_t (b_vec_t)
    ) u_b_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_i    (b_load_i),
        .rd_en_i   (rd_en),
        .rd_step_i (rd_step),
        .vec_o     (b_rd_vec)
    );

    skew_feeder #(
        .LANES (COLS)
    ) u_b_skew (
        .clk     (clk),
        .reset_n (reset_n),
        .vec_i   (b_rd_vec),
        .lanes_o (b_edge)
    );

    systolic_grid u_systolic_grid (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear_i  (clear),
        .a_edge_i (a_edge),
        .b_edge_i (b_edge),
        .sums_o   (sums)
    );

    result_drain u_result_drain (
        .clk      (clk),
        .reset_n  (reset_n),
        .snap_i   (snap),
        .sums_i   (sums),
        .result_o (result_o),
        .done_o   (done_o)
    );

endmodule

`default_nettype wire

// File: tb_matmul_top.sv
`default_nettype none

module tb_matmul_top;

    timeunit 1ns;
    timeprecision 1ps;

    import sa_geometry_pkg::*;
    import sa_stream_pkg::*;

    localparam int SLACK = 2;
    localparam int RUNS  = 6;
    // loads, reads, skew, wait, drain and a little idle per run
    localparam int RUN_CYCLES = 2 * K_MAX + ROWS + COLS + SLACK + ROWS + 8;
    localparam int LIMIT      = 2 * RUNS * RUN_CYCLES + 4 * RUN_CYCLES;

    logic           clk;
    logic           reset_n;
    a_load_t        a_load_i;
    b_load_t        b_load_i;
    logic [K_W-1:0] k_len_i;
    logic           start_i;
    result_beat_t   result_o;
    logic           done_o;

    int a_m [ROWS][K_MAX];
    int b_m [K_MAX][COLS];
    int cycles;
    int error_count;

    matmul_top #(
        .COMPUTE_SLACK (SLACK)
    ) u_matmul_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .a_load_i (a_load_i),
        .b_load_i (b_load_i),
        .k_len_i  (k_len_i),
        .start_i  (start_i),
        .result_o (result_o),
        .done_o   (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: done_o never came within %0d cycles", LIMIT);
            $display("Simulation failed");
            $fatal(1, "run aborted");
        end
    end

    task automatic stop_run();
        error_count++;
        $display("Simulation failed");
        $fatal(1, "run aborted at first error");
    endtask

    // C[r][c] is the sum over k of A[r][k] * B[k][c]
    task automatic expected_row(input int r, input int k_len, output sum_row_t row);
        int s;
        for (int c = 0; c < COLS; c++) begin
            s = 0;
            for (int k = 0; k < k_len; k++) begin
                s += a_m[r][k] * b_m[k][c];
            end
            if (s > (1 << ACC_W) - 1) begin
                $display("model sum C[%0d][%0d] = %0d does not fit the %0d-bit accumulator",
                         r, c, s, ACC_W);
                stop_run();
            end
            row[c] = acc_t'(s);
        end
    endtask

    task automatic check_beat(input result_beat_t got, input int exp_row,
                              input sum_row_t exp_sums);
        if (got.row !== ROW_W'(exp_row)) begin
            $display("CHECK FAILED at %0t: result_o.row got %0d expected %0d",
                     $time, got.row, exp_row);
            stop_run();
        end
        if (got.sums !== exp_sums) begin
            $display("CHECK FAILED at %0t: result_o.sums row %0d got %h expected %h",
                     $time, exp_row, got.sums, exp_sums);
            stop_run();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic fill_random(input bit use_max);
        for (int k = 0; k < K_MAX; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                a_m[r][k] = $urandom_range(0, 255);
                if (use_max && $urandom_range(0, 3) == 0) a_m[r][k] = 255;
            end
            for (int c = 0; c < COLS; c++) begin
                b_m[k][c] = $urandom_range(0, 255);
                if (use_max && $urandom_range(0, 3) == 0) b_m[k][c] = 255;
            end
        end
    endtask

    // A goes in as columns, B as rows
    task automatic load_operands(input int k_len);
        a_vec_t av;
        b_vec_t bv;
        for (int k = 0; k < k_len; k++) begin
            for (int r = 0; r < ROWS; r++) av[r] = element_t'(a_m[r][k]);
            for (int c = 0; c < COLS; c++) bv[c] = element_t'(b_m[k][c]);
            @(negedge clk);
            a_load_i = '{strobe: 1'b1, step: K_W'(k), vec: av};
            b_load_i = '{strobe: 1'b1, step: K_W'(k), vec: bv};
        end
        @(negedge clk);
        a_load_i = '0;
        b_load_i = '0;
    endtask

    // start, then gather beats until done_o, optionally poking start mid-run
    task automatic run_and_check(input int k_len, input bit poke_start);
        int       beats;
        int       waited;
        bit       finished;
        sum_row_t exp_sums;
        beats    = 0;
        waited   = 0;
        finished = 1'b0;
        @(negedge clk);
        start_i = 1'b1;
        k_len_i = K_W'(k_len);
        while (!finished) begin
            @(negedge clk);
            waited++;
            start_i = poke_start && (waited == 3 || waited == k_len + 4);
            k_len_i = poke_start ? K_W'(1) : K_W'(k_len);
            if (result_o.valid) begin
                if (beats < ROWS) begin
                    expected_row(beats, k_len, exp_sums);
                    check_beat(result_o, beats, exp_sums);
                end
                beats++;
            end
            if (done_o) finished = 1'b1;
        end
        start_i = 1'b0;
        check_count("beats before done_o", beats, ROWS);
    endtask

    task automatic expect_quiet(input int n);
        int stray;
        stray = 0;
        repeat (n) begin
            @(negedge clk);
            if (result_o.valid || done_o) stray++;
        end
        check_count("stray result or done cycles", stray, 0);
    endtask

    task automatic identity_a_gives_b();
        fill_random(1'b0);
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < K_MAX; k++) a_m[r][k] = (r == k) ? 1 : 0;
        end
        load_operands(ROWS);
        run_and_check(ROWS, 1'b0);
    endtask

    task automatic random_full_depth();
        fill_random(1'b1);
        // worst-case corner, C[0][0] needs the whole accumulator
        for (int k = 0; k < K_MAX; k++) begin
            a_m[0][k] = 255;
            b_m[k][0] = 255;
        end
        load_operands(K_MAX);
        run_and_check(K_MAX, 1'b0);
    endtask

    task automatic outer_product_k1();
        fill_random(1'b0);
        load_operands(1);
        run_and_check(1, 1'b0);
    endtask

    task automatic back_to_back_runs();
        fill_random(1'b1);
        load_operands(7);
        run_and_check(7, 1'b0);
        fill_random(1'b0);
        load_operands(5);
        run_and_check(5, 1'b0);
    endtask

    task automatic start_while_busy();
        fill_random(1'b0);
        load_operands(8);
        run_and_check(8, 1'b1);
        expect_quiet(K_MAX + ROWS + COLS + SLACK + 4);
    endtask

    initial begin
        void'($urandom(32'h88554513));
        cycles      = 0;
        error_count = 0;
        reset_n     = 1'b0;
        a_load_i    = '0;
        b_load_i    = '0;
        k_len_i     = '0;
        start_i     = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        identity_a_gives_b();
        random_full_depth();
        outer_product_k1();
        back_to_back_runs();
        start_while_busy();

        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
sa_geometry_pkg.sv
sa_stream_pkg.sv
operand_bank.sv
skew_feeder.sv
mac_cell.sv
systolic_grid.sv
matmul_ctrl.sv
result_drain.sv
matmul_top.sv
tb_matmul_top.sv
